// File: common/video_pkg.sv
// ==========================================================
// Video timing package
// Raster widths, flip bases, row-scroll slot and pixel format
// ==========================================================
`default_nettype none

package video_pkg;

    // 9-bit raster coordinate
    typedef logic [8:0] pos_t;

    // One bitplane row of a tile
    localparam int PLANE_W = 8;
    // Three planes per row in the pattern word
    localparam int GFX_W = 3 * PLANE_W;

    // 16-pixel horizontal slot used to read row scroll
    localparam logic [4:0] ROW_READ_SLOT = 5'd8;

    // Flip bases
    localparam pos_t V_FLIP_BASE   = 9'd223;
    localparam pos_t H_FLIP_OFFSET = 9'ha3;

    // Output pixel, MSB first
    typedef struct packed {
        logic       prio;
        logic [2:0] pal;
        logic [2:0] col;
    } pixel_t;

endpackage

`default_nettype wire

// File: common/char_pkg.sv
// ==========================================================
// Character layer package
// Tile map entry, board model encodings and scroll word
// ==========================================================
`default_nettype none

package char_pkg;

    // Board model, picks entry and scroll layout
    typedef enum logic {
        MODEL_A,
        MODEL_B
    } model_e;

    // Tile map word address width
    localparam int MAP_AW = 11;

    // One tile map entry
    typedef logic [15:0] map_word_t;

    // Row-scroll value from the scroll table
    typedef logic [9:0] scroll_t;

    // Tile code width, 9 bits on the alternate encoding
    localparam int CODE_W = 9;

    // Scroll table sits at the top of the map
    localparam logic [4:0] SCROLL_ROW_BASE = 5'h1f;

    // Games with the alternate entry encoding (late model only)
    localparam logic [2:0][7:0] ALT_GAME_IDS = {
        8'h1b,
        8'h1c,
        8'h14
    };

endpackage

`default_nettype wire

// File: common/char_fetch_if.sv
// ==========================================================
// Tile fetch link between control and pixel shifter
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

interface char_fetch_if;
    import video_pkg::*;

    // Tile boundary strobe, one pixel-enable cycle wide
    logic             load;
    // Pattern data, plane 2 in the top byte
    logic [GFX_W-1:0] gfx;
    // Priority and palette of the next tile
    logic [3:0]       attr;
    // Screen flip level
    logic             flip;
    // Pixel enable
    logic             cen;

    modport ctrl (
        output load,
        output gfx,
        output attr,
        output flip,
        output cen
    );

    modport shift (
        input load,
        input gfx,
        input attr,
        input flip,
        input cen
    );

endinterface

`default_nettype wire

// File: char/tile_map_ram.sv
// ==========================================================
// Tile map RAM
// CPU port with byte-lane writes, video port read only
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module tile_map_ram #(
    parameter int AW = 11
) (
    input  wire logic              clk,
    // CPU side
    input  wire logic [AW-1:0]     cpu_addr,
    input  wire char_pkg::map_word_t cpu_wdata,
    input  wire logic [1:0]        cpu_we,
    output char_pkg::map_word_t    cpu_rdata,
    // Video side
    input  wire logic [AW-1:0]     scan_addr,
    output char_pkg::map_word_t    scan_word
);
    import char_pkg::*;

    map_word_t mem [2**AW];

    // CPU port, low and high byte lanes
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        cpu_rdata <= mem[cpu_addr];
    end

    // Video scan port, one clock latency
    always_ff @(posedge clk) begin
        scan_word <= mem[scan_addr];
    end

endmodule

`default_nettype wire

// File: char/char_ctrl.sv
// ==========================================================
// Character layer control
// Flip, map scan, row-scroll latch, tile code and attribute
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module char_ctrl #(
    parameter char_pkg::model_e MODEL = char_pkg::MODEL_A
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          pxl_cen,
    input  wire logic [7:0]                    game_id,
    input  wire logic                          flip,
    input  wire video_pkg::pos_t               hdump,
    input  wire video_pkg::pos_t               vrender,
    // Tile map scan
    output logic [char_pkg::MAP_AW-1:0]        scan_addr,
    input  wire char_pkg::map_word_t           scan_word,
    // Pattern memory
    output logic [char_pkg::CODE_W+3:0]        char_addr,
    input  wire logic [video_pkg::GFX_W-1:0]   char_data,
    // Scroll values
    output char_pkg::scroll_t                  rowscr1,
    output char_pkg::scroll_t                  rowscr2,
    output logic                               altscr1,
    output logic                               altscr2,
    output logic                               scr_start,
    // Game decode
    output logic                               alt_en,
    output logic                               alt_objbank,
    char_fetch_if.ctrl                         fetch
);
    import video_pkg::*;
    import char_pkg::*;

    localparam logic IS_B = (MODEL == MODEL_B);

    pos_t              vf;
    pos_t              hf;
    logic              row_slot;
    logic              load;
    logic              alt_id;
    logic [CODE_W-1:0] code;
    logic [3:0]        attr_nx;

    // Flipped raster position
    always_ff @(posedge clk) begin
        vf <= flip ? V_FLIP_BASE - vrender : vrender;
        hf <= flip ? H_FLIP_OFFSET - hdump : hdump;
    end

    assign row_slot  = hdump[8:4] == ROW_READ_SLOT;
    // Scroll start window, slot after the row read
    assign scr_start = hdump[8:4] == ROW_READ_SLOT + 5'd1;

    // Map scan, two tiles ahead of the beam
    always_comb begin
        scan_addr = {vf[7:3], hf[8:3] + 6'd2};
        // Row read slot looks into the scroll table
        if (row_slot) begin
            scan_addr = IS_B ? {SCROLL_ROW_BASE, hdump[3], vf[7:3]}
                             : {SCROLL_ROW_BASE, vf[7:3], hdump[3]};
        end
    end

    // Row-scroll words, first half then second half of slot
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rowscr1 <= '0;
            rowscr2 <= '0;
            altscr1 <= 1'b0;
            altscr2 <= 1'b0;
        end else if (row_slot) begin
            if (!hdump[3]) begin
                rowscr1 <= scan_word[9:0];
                altscr1 <= IS_B & scan_word[15];
            end else begin
                rowscr2 <= scan_word[9:0];
                altscr2 <= IS_B & scan_word[15];
            end
        end
    end

    // Game id match
    always_comb begin
        alt_id = 1'b0;
        for (int i = 0; i < $size(ALT_GAME_IDS); i++) begin
            if (game_id == ALT_GAME_IDS[i]) begin
                alt_id = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            alt_en      <= 1'b0;
            alt_objbank <= 1'b0;
        end else begin
            alt_en      <= IS_B && alt_id;
            alt_objbank <= IS_B && game_id[4];
        end
    end

    // Last pixel of a tile in raster order
    assign load = pxl_cen && hdump[2:0] == 3'b111;

    // Code and next attribute from the map entry
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            code    <= '0;
            attr_nx <= '0;
        end else if (load) begin
            code <= (IS_B && alt_en) ? scan_word[8:0] : {1'b0, scan_word[7:0]};
            if (!IS_B) begin
                attr_nx <= scan_word[11:8];
            end else if (alt_en) begin
                attr_nx <= {scan_word[15], scan_word[10:8]};
            end else begin
                // Most late-model games
                attr_nx <= {scan_word[15], scan_word[11:9]};
            end
        end
    end

    // Pattern row address, 16-bit words
    assign char_addr = {code, vf[2:0], 1'b0};

    assign fetch.load = load;
    assign fetch.gfx  = char_data;
    assign fetch.attr = attr_nx;
    assign fetch.flip = flip;
    assign fetch.cen  = pxl_cen;

endmodule

`default_nettype wire

// File: char/char_shifter.sv
// ==========================================================
// Character pixel shifter
// Three bitplanes with a one-tile attribute delay
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module char_shifter (
    input  wire logic          clk,
    input  wire logic          rst,
    char_fetch_if.shift        fetch,
    output video_pkg::pixel_t  pxl
);
    import video_pkg::*;

    // Plane 2 in the top slot
    logic [2:0][PLANE_W-1:0] planes;
    logic [3:0]              attr_q;
    logic [2:0]              col;

    function automatic logic [PLANE_W-1:0] shift_plane(
        input logic [PLANE_W-1:0] d,
        input logic               rev
    );
        return rev ? d >> 1 : d << 1;
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            planes <= '0;
            attr_q <= '0;
        end else if (fetch.cen) begin
            if (fetch.load) begin
                planes <= fetch.gfx;
                // Attribute lines up with the tile now shifting
                attr_q <= fetch.attr;
            end else begin
                for (int p = 0; p < 3; p++) begin
                    planes[p] <= shift_plane(planes[p], fetch.flip);
                end
            end
        end
    end

    // Tap MSB normally, LSB when flipped
    always_comb begin
        for (int p = 0; p < 3; p++) begin
            col[p] = fetch.flip ? planes[p][0] : planes[p][PLANE_W-1];
        end
    end

    assign pxl.prio = attr_q[3];
    assign pxl.pal  = attr_q[2:0];
    assign pxl.col  = col;

endmodule

`default_nettype wire

// File: design/char_layer_top.sv
// ==========================================================
// Character tile layer top
// Tile map RAM, scan control and pixel shifter
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module char_layer_top #(
    parameter char_pkg::model_e MODEL = char_pkg::MODEL_A
) (
    input  wire logic                          rst,
    input  wire logic                          clk,
    input  wire logic                          pxl2_cen,
    input  wire logic                          pxl_cen,
    input  wire logic [7:0]                    game_id,
    output logic                               alt_en,
    output logic                               alt_objbank,
    // CPU port
    input  wire logic                          char_cs,
    input  wire logic [char_pkg::MAP_AW:1]     cpu_addr,
    input  wire char_pkg::map_word_t           cpu_dout,
    input  wire logic [1:0]                    dsn,
    output char_pkg::map_word_t                cpu_din,
    // Pattern memory port
    input  wire logic                          char_ok,
    output logic [char_pkg::CODE_W+3:0]        char_addr,
    input  wire logic [video_pkg::GFX_W-1:0]   char_data,
    // Scroll values
    output logic                               scr_start,
    output char_pkg::scroll_t                  rowscr1,
    output char_pkg::scroll_t                  rowscr2,
    output logic                               altscr1,
    output logic                               altscr2,
    // Video
    input  wire logic                          flip,
    input  wire video_pkg::pos_t               vrender,
    input  wire video_pkg::pos_t               hdump,
    output video_pkg::pixel_t                  pxl,
    // pxl2_cen, char_ok and debug_bus are board signals with no role here
    input  wire logic [7:0]                    debug_bus
);
    import char_pkg::*;

    logic [MAP_AW-1:0] scan_addr;
    map_word_t         scan_word;
    logic [1:0]        cpu_we;

    // Active-low byte strobes gated by select
    assign cpu_we = ~dsn & {2{char_cs}};

    char_fetch_if fetch ();

    tile_map_ram #(
        .AW (MAP_AW)
    ) u_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_dout),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_din),
        .scan_addr (scan_addr),
        .scan_word (scan_word)
    );

    char_ctrl #(
        .MODEL (MODEL)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .game_id     (game_id),
        .flip        (flip),
        .hdump       (hdump),
        .vrender     (vrender),
        .scan_addr   (scan_addr),
        .scan_word   (scan_word),
        .char_addr   (char_addr),
        .char_data   (char_data),
        .rowscr1     (rowscr1),
        .rowscr2     (rowscr2),
        .altscr1     (altscr1),
        .altscr2     (altscr2),
        .scr_start   (scr_start),
        .alt_en      (alt_en),
        .alt_objbank (alt_objbank),
        .fetch       (fetch.ctrl)
    );

    char_shifter u_shift (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch.shift),
        .pxl   (pxl)
    );

endmodule

`default_nettype wire

// File: bench/pattern_rom.svh
// ==========================================================
// Pattern memory content model
// Galois LFSR words keyed by pattern address
// ==========================================================

localparam logic [31:0] LFSR_SEED = 32'h6730_854e;
// Right-shifting Galois taps
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ LFSR_TAPS;
    end
    return n;
endfunction

// One LFSR step per bit, plane 0 first
function automatic logic [23:0] pattern_word(input logic [12:0] addr);
    logic [31:0] s;
    logic [23:0] w;
    s = LFSR_SEED ^ {19'd0, addr};
    w = '0;
    for (int i = 0; i < 24; i++) begin
        s = lfsr_next(s);
        w[i] = s[0];
    end
    return w;
endfunction

// File: bench/char_checker.sv
// ==========================================================
// Character layer checker
// Reference model of map, fetch and pixels, per-test report
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module char_checker (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        pxl_cen,
    input  wire logic [7:0]  game_id,
    input  wire logic        flip,
    input  wire logic [8:0]  hdump,
    input  wire logic [8:0]  vrender,
    input  wire logic        char_cs,
    input  wire logic [10:0] cpu_addr,
    input  wire logic [15:0] cpu_dout,
    input  wire logic [1:0]  dsn,
    input  wire logic [15:0] cpu_din,
    input  wire logic [12:0] char_addr,
    input  wire logic [9:0]  rowscr1,
    input  wire logic [9:0]  rowscr2,
    input  wire logic        altscr1,
    input  wire logic        altscr2,
    input  wire logic        scr_start,
    input  wire logic        alt_en,
    input  wire logic        alt_objbank,
    input  wire logic [6:0]  pxl,
    input  wire logic        chk_go,
    input  wire logic [7:0]  chk_op,
    input  wire logic [23:0] chk_exp,
    input  wire logic        run_on,
    output int               test_count,
    output int               fail_count
);
    `include "pattern_rom.svh"

    // Shadow of the tile map, built from observed CPU writes
    logic [15:0] map [2048];
    logic [8:0]  m_vf;
    logic [8:0]  m_hf;
    logic [10:0] m_scan_addr;
    logic [15:0] m_word;
    logic        m_alt_en;
    logic [8:0]  m_code;
    logic [3:0]  m_attr_nx;
    logic [3:0]  m_attr_q;
    logic [23:0] m_gfx;
    // Shifts since the last load
    logic [3:0]  m_n;
    logic        pix_valid;
    logic        flip_q;
    logic        m_load;
    logic [12:0] exp_addr;
    logic        run_q = 1'b0;
    int          run_idx = 0;
    int          run_checks = 0;
    int          run_errs = 0;

    initial begin
        test_count = 0;
        fail_count = 0;
    end

    function automatic logic is_alt_game(input logic [7:0] id);
        return id == 8'h1b || id == 8'h1c || id == 8'h14;
    endfunction

    // Priority and palette, then planes 2..0
    function automatic logic [6:0] expected_pixel(input logic [23:0] gfx,
            input logic [3:0] attr, input logic [3:0] n, input logic rev);
        logic [2:0] col;
        int         bit_idx;
        col = '0;
        bit_idx = rev ? int'(n) : 7 - int'(n);
        for (int p = 0; p < 3; p++) begin
            if (n < 4'd8) begin
                col[p] = gfx[8 * p + bit_idx];
            end
        end
        return {attr, col};
    endfunction

    // Tile ends at dot 7 of the unflipped position
    assign m_load   = pxl_cen && hdump[2:0] == 3'b111;
    assign exp_addr = {m_code, m_vf[2:0], 1'b0};
    // Slot 8 reads the scroll table, late-model layout
    assign m_scan_addr = (hdump[8:4] == 5'd8) ? {5'h1f, hdump[3], m_vf[7:3]}
                                              : {m_vf[7:3], m_hf[8:3] + 6'd2};

    always @(posedge clk) begin
        m_vf   <= flip ? 9'd223 - vrender : vrender;
        m_hf   <= flip ? 9'h0a3 - hdump : hdump;
        m_word <= map[m_scan_addr];
        flip_q <= flip;
        if (char_cs && !dsn[0]) begin
            map[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (char_cs && !dsn[1]) begin
            map[cpu_addr][15:8] <= cpu_dout[15:8];
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_alt_en  <= 1'b0;
            m_code    <= '0;
            m_attr_nx <= '0;
            m_attr_q  <= '0;
            m_gfx     <= '0;
            m_n       <= '0;
            pix_valid <= 1'b0;
        end else begin
            m_alt_en <= is_alt_game(game_id);
            if (m_load) begin
                m_code    <= m_alt_en ? m_word[8:0] : {1'b0, m_word[7:0]};
                m_attr_nx <= m_alt_en ? {m_word[15], m_word[10:8]}
                                      : {m_word[15], m_word[11:9]};
            end
            if (pxl_cen) begin
                if (m_load) begin
                    m_gfx     <= pattern_word(exp_addr);
                    m_attr_q  <= m_attr_nx;
                    m_n       <= '0;
                    pix_valid <= 1'b1;
                end else if (m_n != 4'd8) begin
                    m_n <= m_n + 4'd1;
                end
            end
            // Shift direction broken until the next load
            if (flip != flip_q) begin
                pix_valid <= 1'b0;
            end
        end
    end

    task automatic note_mismatch(input string what, input logic [23:0] e,
                                 input logic [23:0] got);
        run_errs++;
        if (run_errs <= 4) begin
            $display("FAILED %0t: %s expected %h got %h", $time, what, e, got);
        end
    endtask

    task automatic check_record();
        logic [23:0] got;
        string       what;
        case (chk_op)
            8'h02: begin
                got  = {8'h00, cpu_din};
                what = "cpu read-back";
            end
            8'h03: begin
                got  = {22'd0, alt_en, alt_objbank};
                what = "game id decode";
            end
            default: begin
                got  = {2'b00, altscr2, altscr1, rowscr2, rowscr1};
                what = "row scroll";
            end
        endcase
        test_count++;
        if (got !== chk_exp) begin
            fail_count++;
            $display("FAILED %0t: %s expected %h got %h", $time, what, chk_exp, got);
        end else begin
            $display("test %0d %s: ok", test_count, what);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (chk_go) begin
            check_record();
        end
        if (run_on && !run_q) begin
            run_idx++;
            run_checks = 0;
            run_errs = 0;
        end
        if (run_on) begin
            run_checks++;
            if (scr_start !== (hdump[8:4] == 5'd9)) begin
                note_mismatch("scr_start", {23'd0, hdump[8:4] == 5'd9}, {23'd0, scr_start});
            end
            if (char_addr !== exp_addr) begin
                note_mismatch("char_addr", {11'd0, exp_addr}, {11'd0, char_addr});
            end
            if (pix_valid && pxl !== expected_pixel(m_gfx, m_attr_q, m_n, flip)) begin
                note_mismatch("pxl", {17'd0, expected_pixel(m_gfx, m_attr_q, m_n, flip)},
                              {17'd0, pxl});
            end
        end
        if (!run_on && run_q) begin
            test_count++;
            if (run_errs != 0) begin
                fail_count++;
                $display("test %0d raster run %0d: %0d mismatches in %0d cycles",
                         test_count, run_idx, run_errs, run_checks);
            end else begin
                $display("test %0d raster run %0d: ok, %0d cycles", test_count, run_idx,
                         run_checks);
            end
        end
        run_q = run_on;
    end

endmodule

`default_nettype wire

// File: bench/char_tb.sv
// ==========================================================
// Character layer testbench
// Raster, CPU stimulus from file, pattern memory model
// ==========================================================
`timescale 1ns/1ns
`default_nettype none

module char_tb;
    import char_pkg::*;
    `include "pattern_rom.svh"

    localparam int MAX_REC   = 32;
    localparam int LINES     = 264;
    localparam int LINE_CLKS = 1024;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic        flip;
    logic        char_cs;
    logic        char_ok;
    logic [7:0]  game_id;
    logic [7:0]  debug_bus;
    logic [8:0]  hdump;
    logic [8:0]  vrender;
    logic [10:0] cpu_addr;
    logic [15:0] cpu_dout;
    logic [15:0] cpu_din;
    logic [1:0]  dsn;
    logic [12:0] char_addr;
    logic [23:0] char_data;
    logic [9:0]  rowscr1;
    logic [9:0]  rowscr2;
    logic        altscr1;
    logic        altscr2;
    logic        scr_start;
    logic        alt_en;
    logic        alt_objbank;
    logic [6:0]  pxl;
    // Checker requests
    logic        chk_go;
    logic        run_on;
    logic [7:0]  chk_op;
    logic [23:0] chk_exp;
    int          test_count;
    int          fail_count;
    // Each record holds op, address, data and expected value
    logic [63:0] recs [MAX_REC];
    int          n_rec;
    int          bad_recs = 0;
    int          limit;
    int          cycles = 0;

    // Pattern memory answers at once
    assign char_data = pattern_word(char_addr);

    char_layer_top #(
        .MODEL (MODEL_B)
    ) DUT (
        .rst (rst), .clk (clk), .pxl2_cen (pxl2_cen), .pxl_cen (pxl_cen),
        .game_id (game_id), .alt_en (alt_en), .alt_objbank (alt_objbank),
        .char_cs (char_cs), .cpu_addr (cpu_addr), .cpu_dout (cpu_dout),
        .dsn (dsn), .cpu_din (cpu_din), .char_ok (char_ok),
        .char_addr (char_addr), .char_data (char_data), .scr_start (scr_start),
        .rowscr1 (rowscr1), .rowscr2 (rowscr2), .altscr1 (altscr1),
        .altscr2 (altscr2), .flip (flip), .vrender (vrender), .hdump (hdump),
        .pxl (pxl), .debug_bus (debug_bus)
    );

    char_checker u_chk (
        .clk (clk), .rst (rst), .pxl_cen (pxl_cen), .game_id (game_id),
        .flip (flip), .hdump (hdump), .vrender (vrender), .char_cs (char_cs),
        .cpu_addr (cpu_addr), .cpu_dout (cpu_dout), .dsn (dsn),
        .cpu_din (cpu_din), .char_addr (char_addr), .rowscr1 (rowscr1),
        .rowscr2 (rowscr2), .altscr1 (altscr1), .altscr2 (altscr2),
        .scr_start (scr_start), .alt_en (alt_en), .alt_objbank (alt_objbank),
        .pxl (pxl), .chk_go (chk_go), .chk_op (chk_op), .chk_exp (chk_exp),
        .run_on (run_on), .test_count (test_count), .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Each raster dot holds one idle and one enabled clock
    always @(posedge clk) begin
        #2;
        if (pxl_cen) begin
            if (hdump == 9'd511) begin
                vrender = (vrender == 9'd263) ? 9'd0 : vrender + 9'd1;
            end
            hdump = hdump + 9'd1;
        end
        pxl_cen = ~pxl_cen;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: no result after %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [15:0] fill_value(input logic [10:0] a);
        return {a[4:0], a} ^ 16'ha55a;
    endfunction

    task automatic write_word(input logic [10:0] a, input logic [15:0] d,
                              input logic [1:0] strobes);
        @(posedge clk);
        #2;
        char_cs  = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
        dsn      = strobes;
        @(posedge clk);
        #2;
        char_cs = 1'b0;
        dsn     = 2'b11;
    endtask

    task automatic request_check(input logic [7:0] op, input logic [23:0] e);
        @(posedge clk);
        #2;
        chk_op  = op;
        chk_exp = e;
        chk_go  = 1'b1;
        @(posedge clk);
        #2;
        chk_go = 1'b0;
    endtask

    task automatic run_record(input logic [63:0] rec);
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] d;
        logic [23:0] e;
        op = rec[63:56];
        a  = rec[55:40];
        d  = rec[39:24];
        e  = rec[23:0];
        case (op)
            8'h01: write_word(a[10:0], d, e[1:0]);
            8'h02: begin
                @(posedge clk);
                #2 cpu_addr = a[10:0];
                request_check(op, e);
            end
            8'h03: begin
                @(posedge clk);
                #2 game_id = d[7:0];
                repeat (2) @(posedge clk);
                request_check(op, e);
            end
            8'h04: begin
                @(posedge clk);
                #2 flip = d[0];
            end
            // Scroll is settled well after slot 8 of the line
            8'h05: begin
                while (!(vrender == a[8:0] && hdump == 9'd160)) @(posedge clk);
                request_check(op, e);
            end
            8'h06: begin
                @(posedge clk);
                #2 run_on = 1'b1;
                repeat (int'(d) * LINE_CLKS) @(posedge clk);
                #2 run_on = 1'b0;
                @(posedge clk);
            end
            default: begin
                bad_recs++;
                $display("Unknown opcode %h in stimulus record", op);
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b0;
        pxl2_cen = 1'b1;
        char_ok = 1'b1;
        debug_bus = 8'd0;
        flip = 1'b0;
        char_cs = 1'b0;
        game_id = 8'd0;
        hdump = 9'd0;
        vrender = 9'd0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        chk_go = 1'b0;
        chk_op = 8'd0;
        chk_exp = '0;
        run_on = 1'b0;
        for (int i = 0; i < MAX_REC; i++) begin
            recs[i] = '0;
        end
        $readmemh("bench/char_stimulus.mem", recs);
        n_rec = 0;
        while (n_rec < MAX_REC && recs[n_rec][63:56] != 8'h00) begin
            n_rec++;
        end
        limit = n_rec * 1100 + 2 * LINES * LINE_CLKS;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        // Whole map gets a known pattern first
        for (int a = 0; a < 2048; a++) begin
            write_word(11'(a), fill_value(11'(a)), 2'b00);
        end
        for (int r = 0; r < n_rec; r++) begin
            run_record(recs[r]);
        end
        @(posedge clk);
        $display("Summary: %0d tests, %0d failed", test_count, fail_count);
        if (fail_count == 0 && bad_recs == 0 && test_count > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/char_stimulus.mem
// op_addr_data_expect: op 01 write (expect = dsn), 02 read, 03 game id, 04 flip
// 05 scroll at line addr (expect = alt2 alt1 scr2 scr1), 06 run data lines, 00 end
01_0012_a5c3_000000
01_0012_7e00_000001
01_0013_00ff_000002
02_0012_0000_007ec3
02_0013_0000_003dff
01_07c5_8123_000000
01_07e5_0345_000000
05_0028_0000_1d1523
03_0000_001b_000003
03_0000_000a_000000
03_0000_0013_000001
06_0000_0003_000000
03_0000_0014_000003
06_0000_0003_000000
04_0000_0001_000000
06_0000_0003_000000
00_0000_0000_000000

// File: src.f
+incdir+bench
common/video_pkg.sv
common/char_pkg.sv
common/char_fetch_if.sv
char/tile_map_ram.sv
char/char_ctrl.sv
char/char_shifter.sv
design/char_layer_top.sv
bench/char_checker.sv
bench/char_tb.sv

// File: Makefile
# Verilator build for the character layer testbench

VERILATOR ?= verilator
TOP       ?= char_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
